// File: flist.f
+incdir+logic
logic/tetris_pkg.sv
logic/board_ram.sv
logic/board_arbiter.sv
logic/piece_mover.sv
logic/row_sweeper.sv
logic/tetris_board_top.sv
verification/tb_tetris_board.sv

// File: Bender.yml
package:
  name: tetris_board

sources:
  - include_dirs:
      - logic
    files:
      - logic/tetris_pkg.sv
      - logic/board_ram.sv
      - logic/board_arbiter.sv
      - logic/piece_mover.sv
      - logic/row_sweeper.sv
      - logic/tetris_board_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_tetris_board.sv

// File: verification/tb_tetris_board.sv
`timescale 1ns/1ns
`include "tetris_consts.svh"

module tb_tetris_board;
	import tetris_pkg::*;

	localparam int clear_cycles = `BOARD_W * `BOARD_H;
	localparam int shift_cycles = 3 * clear_cycles; // read, wait, write per cell
	// the whole run needs about clear + two shifts + one full board read
	localparam int run_cycles = clear_cycles + 3 * shift_cycles;
	localparam int watchdog_cycles = 20 * run_cycles; // ample margin over the run

	logic        clk;
	logic        reset;
	logic        spawn_i;
	board_x_t    spawn_x [`PIECE_CELLS];
	board_y_t    spawn_y [`PIECE_CELLS];
	cell_color_t spawn_color;
	logic        move_i;
	logic [7:0]  key;
	board_x_t    disp_x;
	board_y_t    disp_y;
	logic        ready;
	logic        moved;
	logic        blocked;
	logic        landed;
	logic [7:0]  lines;
	cell_color_t disp_color;

	cell_color_t model [`BOARD_H][`BOARD_W]; // expected board
	int          cur_x [`PIECE_CELLS]; // piece the mover should hold
	int          cur_y [`PIECE_CELLS];
	cell_color_t cur_color;
	int          tgt_x [`PIECE_CELLS];
	int          tgt_y [`PIECE_CELLS];
	int          seen_x [$]; // cells picked in the first test
	int          seen_y [$];
	int          exp_lines;
	int          checks;
	int          errors;
	int          seed;

	tetris_board_top u_dut (.clk(clk), .reset(reset), .spawn_i(spawn_i),
		.spawn_x_i(spawn_x), .spawn_y_i(spawn_y), .spawn_color_i(spawn_color),
		.move_i(move_i), .key_i(key), .disp_x_i(disp_x), .disp_y_i(disp_y),
		.ready_o(ready), .moved_o(moved), .blocked_o(blocked), .landed_o(landed),
		.lines_o(lines), .disp_color_o(disp_color));

	always #10 clk = ~clk;

	task automatic check_color(input string name, input cell_color_t exp, input cell_color_t got);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp, got);
		end
	endtask

	task automatic check_count(input string name, input logic [7:0] exp, input logic [7:0] got);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp, got);
		end
	endtask

	// pulses packed as {moved, blocked, landed}
	task automatic check_pulse(input string name, input logic [2:0] exp, input logic [2:0] got);
		checks++;
		if (got == 3'b000)
		begin
			errors++;
			$display("no moved/blocked/landed pulse seen after the move command");
		end
		else if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp, got);
		end
	endtask

	task automatic wait_ready(input int limit);
		int n;
		n = 0;
		while (!ready && n < limit)
		begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!ready)
		begin
			errors++;
			$display("ready_o did not rise within %0d cycles", limit);
		end
	endtask

	// the colour comes out two edges after the address
	task automatic read_cell(input int x, input int y, output cell_color_t c);
		disp_x = board_x_t'(x);
		disp_y = board_y_t'(y);
		@(posedge clk);
		@(posedge clk);
		#1 c = disp_color;
		#1;
	endtask

	task automatic check_cell(input int x, input int y);
		cell_color_t c;
		read_cell(x, y, c);
		check_color($sformatf("disp_color_o(%0d,%0d)", x, y), model[y][x], c);
	endtask

	task automatic check_seen();
		foreach (seen_x[i])
			check_cell(seen_x[i], seen_y[i]);
	endtask

	task automatic spawn_piece(input int xs [`PIECE_CELLS], input int ys [`PIECE_CELLS],
		input cell_color_t c);
		wait_ready(100);
		for (int i = 0; i < `PIECE_CELLS; i++)
		begin
			spawn_x[i] = board_x_t'(xs[i]);
			spawn_y[i] = board_y_t'(ys[i]);
			model[ys[i]][xs[i]] = c;
		end
		spawn_color = c;
		spawn_i = 1'b1;
		@(posedge clk);
		#2 spawn_i = 1'b0;
		if (ready)
		begin
			errors++;
			$display("ready_o stayed high after an accepted spawn");
		end
		cur_x = xs;
		cur_y = ys;
		cur_color = c;
		wait_ready(20);
	endtask

	// full rows drop everything above them by one and the row is looked at again
	task automatic model_sweep();
		int r;
		bit full;
		r = `Y_MAX;
		while (r >= 0)
		begin
			full = 1'b1;
			for (int x = 0; x < `BOARD_W; x++)
				if (model[r][x] == `COLOR_EMPTY)
					full = 1'b0;
			if (full)
			begin
				for (int rr = r; rr > 0; rr--)
					for (int x = 0; x < `BOARD_W; x++)
						model[rr][x] = model[rr-1][x];
				for (int x = 0; x < `BOARD_W; x++)
					model[0][x] = `COLOR_EMPTY;
				exp_lines++;
			end
			else
				r--;
		end
	endtask

	task automatic model_move(input int dx, input int dy, output logic [2:0] pulse);
		bit legal;
		legal = 1'b1;
		for (int i = 0; i < `PIECE_CELLS; i++)
		begin
			tgt_x[i] = cur_x[i] + dx;
			tgt_y[i] = cur_y[i] + dy;
			if (tgt_x[i] < 0 || tgt_x[i] > `X_MAX || tgt_y[i] < 0 || tgt_y[i] > `Y_MAX)
				legal = 1'b0;
			else if (model[tgt_y[i]][tgt_x[i]] != `COLOR_EMPTY &&
				model[tgt_y[i]][tgt_x[i]] != cur_color)
				legal = 1'b0; // another piece is in the way
		end
		if (legal)
		begin
			for (int i = 0; i < `PIECE_CELLS; i++)
				model[cur_y[i]][cur_x[i]] = `COLOR_EMPTY;
			for (int i = 0; i < `PIECE_CELLS; i++)
				model[tgt_y[i]][tgt_x[i]] = cur_color;
			cur_x = tgt_x;
			cur_y = tgt_y;
			pulse = 3'b100;
		end
		else if (dy == 1)
		begin
			pulse = 3'b001;
			model_sweep();
		end
		else
			pulse = 3'b010;
	endtask

	task automatic move_piece(input logic [7:0] code, input int dx, input int dy);
		int old_x [`PIECE_CELLS];
		int old_y [`PIECE_CELLS];
		logic [2:0] exp_pulse;
		logic [2:0] got_pulse;
		int n;
		old_x = cur_x;
		old_y = cur_y;
		wait_ready(100);
		key = code;
		move_i = 1'b1;
		@(posedge clk);
		#2 move_i = 1'b0;
		got_pulse = 3'b000;
		n = 0;
		while (got_pulse == 3'b000 && n < 200)
		begin
			@(posedge clk);
			#2 got_pulse = {moved, blocked, landed};
			n++;
		end
		model_move(dx, dy, exp_pulse);
		check_pulse("{moved_o,blocked_o,landed_o}", exp_pulse, got_pulse);
		wait_ready(3 * shift_cycles);
		for (int i = 0; i < `PIECE_CELLS; i++)
			check_cell(old_x[i], old_y[i]);
		for (int i = 0; i < `PIECE_CELLS; i++)
			if (tgt_x[i] >= 0 && tgt_x[i] <= `X_MAX && tgt_y[i] >= 0 && tgt_y[i] <= `Y_MAX)
				check_cell(tgt_x[i], tgt_y[i]);
	endtask

	task automatic report_test(input string name, input int err_mark);
		$display("test %-10s %s", name, (errors == err_mark) ? "ok" : "FAILED");
	endtask

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, run stuck", watchdog_cycles);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		int err_mark;
		int p;
		clk = 1'b0;
		reset = 1'b1;
		spawn_i = 1'b0;
		spawn_color = 3'd0;
		move_i = 1'b0;
		key = 8'h00;
		disp_x = 5'd0;
		disp_y = 6'd0;
		for (int i = 0; i < `PIECE_CELLS; i++)
		begin
			spawn_x[i] = 5'd0;
			spawn_y[i] = 6'd0;
		end
		seed = 2;
		checks = 0;
		errors = 0;
		exp_lines = 0;
		for (int y = 0; y < `BOARD_H; y++)
			for (int x = 0; x < `BOARD_W; x++)
				model[y][x] = `COLOR_EMPTY;
		repeat (10) @(posedge clk);
		#2 reset = 1'b0;

		err_mark = errors;
		wait_ready(clear_cycles + 50);
		seen_x = '{0, `X_MAX, 0, `X_MAX}; // corners first
		seen_y = '{0, 0, `Y_MAX, `Y_MAX};
		repeat (30)
		begin
			seen_x.push_back($unsigned($random(seed)) % `BOARD_W);
			seen_y.push_back($unsigned($random(seed)) % `BOARD_H);
		end
		check_seen();
		report_test("clear", err_mark);

		err_mark = errors;
		spawn_piece('{5, 6, 7, 6}, '{10, 10, 10, 11}, 3'd2); // T shape
		for (int i = 0; i < `PIECE_CELLS; i++)
			check_cell(cur_x[i], cur_y[i]);
		check_seen();
		report_test("spawn", err_mark);

		err_mark = errors;
		move_piece(`KEY_DOWN, 0, 1);
		move_piece(`KEY_LEFT, -1, 0);
		move_piece(`KEY_RIGHT, 1, 0);
		report_test("moves", err_mark);

		err_mark = errors;
		spawn_piece('{3, 4, 3, 4}, '{20, 20, 21, 21}, 3'd4); // obstacle square
		spawn_piece('{0, 1, 2, 0}, '{20, 20, 20, 21}, 3'd5); // L against the wall
		move_piece(`KEY_LEFT, -1, 0);
		move_piece(`KEY_RIGHT, 1, 0);
		check_cell(3, 20);
		check_cell(4, 21);
		report_test("blocked", err_mark);

		err_mark = errors;
		for (p = 0; p < 5; p++)
			spawn_piece('{4*p, 4*p+1, 4*p+2, 4*p+3}, '{40, 40, 40, 40}, cell_color_t'(p + 1));
		spawn_piece('{8, 9, 10, 11}, '{38, 38, 38, 38}, 3'd6); // marker
		spawn_piece('{17, 18, 19, 20}, '{40, 40, 40, 40}, 3'd3);
		move_piece(`KEY_DOWN, 0, 1);
		check_count("lines_o", 8'(exp_lines), lines);
		for (int y = 0; y < `BOARD_H; y++)
			for (int x = 0; x < `BOARD_W; x++)
				check_cell(x, y);
		report_test("line", err_mark);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule : tb_tetris_board

// File: logic/tetris_board_top.sv
`timescale 1ns/1ns
`include "tetris_consts.svh"

module tetris_board_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    spawn_i,
	input  tetris_pkg::board_x_t    spawn_x_i [`PIECE_CELLS],
	input  tetris_pkg::board_y_t    spawn_y_i [`PIECE_CELLS],
	input  tetris_pkg::cell_color_t spawn_color_i,
	input  logic                    move_i,
	input  logic [7:0]              key_i,
	input  tetris_pkg::board_x_t    disp_x_i,
	input  tetris_pkg::board_y_t    disp_y_i,
	output logic                    ready_o,
	output logic                    moved_o,
	output logic                    blocked_o,
	output logic                    landed_o,
	output logic [7:0]              lines_o,
	output tetris_pkg::cell_color_t disp_color_o
);
	import tetris_pkg::*;

	logic        sw_req, sw_we, sw_gnt, pm_req, pm_we, pm_gnt;
	board_x_t    sw_x, pm_x, mem_x;
	board_y_t    sw_y, pm_y, mem_y;
	cell_color_t sw_color, pm_color, mem_color, rcolor;
	logic        mem_we;
	logic        sweep_busy;

	assign disp_color_o = rcolor; // all readers share the read port

	board_ram u_ram (.clk(clk), .we_i(mem_we), .x_i(mem_x), .y_i(mem_y),
		.wcolor_i(mem_color), .rcolor_o(rcolor));

	board_arbiter u_arb (.clk(clk), .reset(reset),
		.sw_req_i(sw_req), .sw_we_i(sw_we), .sw_x_i(sw_x), .sw_y_i(sw_y),
		.sw_color_i(sw_color), .sw_gnt_o(sw_gnt),
		.pm_req_i(pm_req), .pm_we_i(pm_we), .pm_x_i(pm_x), .pm_y_i(pm_y),
		.pm_color_i(pm_color), .pm_gnt_o(pm_gnt),
		.disp_x_i(disp_x_i), .disp_y_i(disp_y_i),
		.mem_we_o(mem_we), .mem_x_o(mem_x), .mem_y_o(mem_y), .mem_color_o(mem_color));

	piece_mover u_mover (.clk(clk), .reset(reset), .spawn_i(spawn_i),
		.spawn_x_i(spawn_x_i), .spawn_y_i(spawn_y_i), .spawn_color_i(spawn_color_i),
		.move_i(move_i), .key_i(key_i), .sweep_busy_i(sweep_busy),
		.req_o(pm_req), .we_o(pm_we), .x_o(pm_x), .y_o(pm_y), .color_o(pm_color),
		.gnt_i(pm_gnt), .rcolor_i(rcolor), .land_o(landed_o), .ready_o(ready_o),
		.moved_o(moved_o), .blocked_o(blocked_o));

	row_sweeper u_sweep (.clk(clk), .reset(reset), .land_i(landed_o),
		.req_o(sw_req), .we_o(sw_we), .x_o(sw_x), .y_o(sw_y), .color_o(sw_color),
		.gnt_i(sw_gnt), .rcolor_i(rcolor), .busy_o(sweep_busy), .lines_o(lines_o));

endmodule : tetris_board_top

// File: logic/row_sweeper.sv
`timescale 1ns/1ns
`include "tetris_consts.svh"

module row_sweeper (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    land_i,
	output logic                    req_o,
	output logic                    we_o,
	output tetris_pkg::board_x_t    x_o,
	output tetris_pkg::board_y_t    y_o,
	output tetris_pkg::cell_color_t color_o,
	input  logic                    gnt_i,
	input  tetris_pkg::cell_color_t rcolor_i,
	output logic                    busy_o,
	output logic [7:0]              lines_o
);
	import tetris_pkg::*;

	sweeper_state_t state;
	board_x_t       x;
	board_y_t       row; // row being scanned, also clear row
	board_y_t       cy; // destination row of the copy
	cell_color_t    hold_color;
	logic           x_last;

	assign x_last = (x == 5'(`X_MAX));
	assign busy_o = (state != ss_idle);

	always_comb
	begin
		req_o = 1'b1;
		we_o = 1'b0;
		x_o = x;
		y_o = row;
		color_o = `COLOR_EMPTY;
		case (state)
			ss_clear: we_o = 1'b1;
			ss_scan_rd: ;
			ss_copy_rd: y_o = cy - 6'd1; // cell just above
			ss_copy_wr:
			begin
				we_o = 1'b1;
				y_o = cy;
				color_o = hold_color;
			end
			ss_top_clear:
			begin
				we_o = 1'b1;
				y_o = 6'd0;
			end
			default: req_o = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
		if (state == ss_copy_wait)
			hold_color <= rcolor_i;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ss_clear;
			x <= 5'd0;
			row <= 6'd0;
			cy <= 6'd0;
			lines_o <= 8'd0;
		end
		else
		begin
			case (state)
				ss_clear:
					if (gnt_i)
					begin
						x <= x_last ? 5'd0 : x + 5'd1;
						if (x_last && row == 6'(`Y_MAX))
							state <= ss_idle;
						else if (x_last)
							row <= row + 6'd1;
					end
				ss_idle:
					if (land_i)
					begin
						x <= 5'd0;
						row <= 6'(`Y_MAX); // scan from the bottom
						state <= ss_scan_rd;
					end
				ss_scan_rd:
					if (gnt_i)
						state <= ss_scan_wait;
				ss_scan_wait:
					if (rcolor_i == `COLOR_EMPTY)
					begin
						x <= 5'd0; // hole found, row stays
						if (row == 6'd0)
							state <= ss_idle;
						else
						begin
							row <= row - 6'd1;
							state <= ss_scan_rd;
						end
					end
					else if (x_last)
					begin
						x <= 5'd0; // full row
						cy <= row;
						state <= (row == 6'd0) ? ss_top_clear : ss_copy_rd;
					end
					else
					begin
						x <= x + 5'd1;
						state <= ss_scan_rd;
					end
				ss_copy_rd:
					if (gnt_i)
						state <= ss_copy_wait;
				ss_copy_wait:
					state <= ss_copy_wr;
				ss_copy_wr:
					if (gnt_i)
					begin
						x <= x_last ? 5'd0 : x + 5'd1;
						if (x_last && cy == 6'd1)
							state <= ss_top_clear;
						else
						begin
							if (x_last)
								cy <= cy - 6'd1;
							state <= ss_copy_rd;
						end
					end
				ss_top_clear:
					if (gnt_i)
					begin
						x <= x_last ? 5'd0 : x + 5'd1;
						if (x_last)
						begin
							lines_o <= lines_o + 8'd1;
							state <= ss_scan_rd; // same row again
						end
					end
				default:
					state <= ss_idle;
			endcase
		end
	end

	// the mover only lands a piece while the sweeper rests
	a_land_when_idle: assert property (@(posedge clk) disable iff (reset)
		land_i |-> (state == ss_idle));

endmodule : row_sweeper

// File: logic/piece_mover.sv
`timescale 1ns/1ns
`include "tetris_consts.svh"

module piece_mover (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    spawn_i,
	input  tetris_pkg::board_x_t    spawn_x_i [`PIECE_CELLS],
	input  tetris_pkg::board_y_t    spawn_y_i [`PIECE_CELLS],
	input  tetris_pkg::cell_color_t spawn_color_i,
	input  logic                    move_i,
	input  logic [7:0]              key_i,
	input  logic                    sweep_busy_i,
	output logic                    req_o,
	output logic                    we_o,
	output tetris_pkg::board_x_t    x_o,
	output tetris_pkg::board_y_t    y_o,
	output tetris_pkg::cell_color_t color_o,
	input  logic                    gnt_i,
	input  tetris_pkg::cell_color_t rcolor_i,
	output logic                    land_o,
	output logic                    ready_o,
	output logic                    moved_o,
	output logic                    blocked_o
);
	import tetris_pkg::*;

	mover_state_t state;
	move_op_t     op;
	move_op_t     key_op;
	board_x_t     cell_x [`PIECE_CELLS];
	board_y_t     cell_y [`PIECE_CELLS];
	cell_color_t  piece_color;
	logic [5:0]   nxt_x_ext [`PIECE_CELLS]; // one spare bit catches under/overflow
	logic [6:0]   nxt_y_ext [`PIECE_CELLS];
	logic [`PIECE_CELLS-1:0] nxt_in;
	logic [1:0]   k; // cell index
	logic         last_cell;
	logic         all_free;
	logic         cell_free;
	logic         spawn_take;
	logic         move_take;

	always_comb
	begin
		case (key_i)
			`KEY_DOWN: key_op = move_down;
			`KEY_LEFT: key_op = move_left;
			`KEY_RIGHT: key_op = move_right;
			default: key_op = move_none;
		endcase
	end

	// target position of every cell for the pending move
	always_comb
	begin
		for (int i = 0; i < `PIECE_CELLS; i++)
		begin
			nxt_x_ext[i] = {1'b0, cell_x[i]};
			nxt_y_ext[i] = {1'b0, cell_y[i]};
			case (op)
				move_down: nxt_y_ext[i] = {1'b0, cell_y[i]} + 7'd1;
				move_left: nxt_x_ext[i] = {1'b0, cell_x[i]} - 6'd1;
				move_right: nxt_x_ext[i] = {1'b0, cell_x[i]} + 6'd1;
				default: ;
			endcase
			nxt_in[i] = (nxt_x_ext[i] <= 6'(`X_MAX)) && (nxt_y_ext[i] <= 7'(`Y_MAX));
		end
	end

	assign last_cell = (k == 2'(`PIECE_CELLS - 1));
	assign cell_free = nxt_in[k] && (rcolor_i == `COLOR_EMPTY || rcolor_i == piece_color);
	assign ready_o = (state == ms_idle) && !sweep_busy_i;
	assign spawn_take = ready_o && spawn_i;
	assign move_take = ready_o && !spawn_i && move_i && (key_op != move_none);

	always_comb
	begin
		req_o = 1'b0;
		we_o = 1'b0;
		x_o = cell_x[k];
		y_o = cell_y[k];
		color_o = piece_color;
		case (state)
			ms_check_rd:
			begin
				req_o = 1'b1;
				x_o = nxt_x_ext[k][4:0];
				y_o = nxt_y_ext[k][5:0];
			end
			ms_erase:
			begin
				req_o = 1'b1;
				we_o = 1'b1;
				color_o = `COLOR_EMPTY;
			end
			ms_draw:
			begin
				req_o = 1'b1;
				we_o = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (spawn_take)
		begin
			cell_x <= spawn_x_i;
			cell_y <= spawn_y_i;
			piece_color <= spawn_color_i;
		end
		else if (state == ms_erase && gnt_i && last_cell)
		begin
			for (int i = 0; i < `PIECE_CELLS; i++)
			begin
				cell_x[i] <= nxt_x_ext[i][4:0]; // old cells gone so take the new spot
				cell_y[i] <= nxt_y_ext[i][5:0];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ms_idle;
			op <= move_none;
			k <= 2'd0;
			all_free <= 1'b0;
			land_o <= 1'b0;
			moved_o <= 1'b0;
			blocked_o <= 1'b0;
		end
		else
		begin
			land_o <= 1'b0;
			moved_o <= 1'b0;
			blocked_o <= 1'b0;
			case (state)
				ms_idle:
					if (spawn_take)
					begin
						op <= move_none; // spawn draws without checks
						k <= 2'd0;
						state <= ms_draw;
					end
					else if (move_take)
					begin
						op <= key_op;
						k <= 2'd0;
						all_free <= 1'b1;
						state <= ms_check_rd;
					end
				ms_check_rd:
					if (gnt_i)
						state <= ms_check_wait;
				ms_check_wait:
				begin
					all_free <= all_free && cell_free;
					k <= k + 2'd1;
					state <= last_cell ? ms_decide : ms_check_rd;
				end
				ms_decide:
					if (all_free)
						state <= ms_erase;
					else
					begin
						land_o <= (op == move_down); // blocked down means landed
						blocked_o <= (op != move_down);
						state <= ms_done;
					end
				ms_erase:
					if (gnt_i)
					begin
						k <= k + 2'd1;
						if (last_cell)
							state <= ms_draw;
					end
				ms_draw:
					if (gnt_i)
					begin
						k <= k + 2'd1;
						if (last_cell && op == move_none)
							state <= ms_idle;
						else if (last_cell)
						begin
							moved_o <= 1'b1;
							state <= ms_done;
						end
					end
				default:
					state <= ms_idle;
			endcase
		end
	end

	// the mover rests through every sweep so a move key cannot touch the piece
	a_no_move_while_sweep: assert property (@(posedge clk) disable iff (reset)
		sweep_busy_i |-> (state == ms_idle));

endmodule : piece_mover

// File: logic/board_arbiter.sv
`timescale 1ns/1ns
`include "tetris_consts.svh"

module board_arbiter (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    sw_req_i,
	input  logic                    sw_we_i,
	input  tetris_pkg::board_x_t    sw_x_i,
	input  tetris_pkg::board_y_t    sw_y_i,
	input  tetris_pkg::cell_color_t sw_color_i,
	output logic                    sw_gnt_o,
	input  logic                    pm_req_i,
	input  logic                    pm_we_i,
	input  tetris_pkg::board_x_t    pm_x_i,
	input  tetris_pkg::board_y_t    pm_y_i,
	input  tetris_pkg::cell_color_t pm_color_i,
	output logic                    pm_gnt_o,
	input  tetris_pkg::board_x_t    disp_x_i,
	input  tetris_pkg::board_y_t    disp_y_i,
	output logic                    mem_we_o,
	output tetris_pkg::board_x_t    mem_x_o,
	output tetris_pkg::board_y_t    mem_y_o,
	output tetris_pkg::cell_color_t mem_color_o
);
	import tetris_pkg::*;

	board_x_t disp_x_q;
	board_y_t disp_y_q;
	logic     disp_gnt;

	always_ff @(posedge clk)
	begin
		disp_x_q <= disp_x_i; // display address gets one grant cycle
		disp_y_q <= disp_y_i;
	end

	assign sw_gnt_o = sw_req_i; // sweeper always wins
	assign pm_gnt_o = pm_req_i && !sw_req_i;
	assign disp_gnt = !sw_req_i && !pm_req_i;

	always_comb
	begin
		mem_we_o = 1'b0;
		mem_x_o = disp_x_q;
		mem_y_o = disp_y_q;
		mem_color_o = `COLOR_EMPTY;
		if (sw_gnt_o)
		begin
			mem_we_o = sw_we_i;
			mem_x_o = sw_x_i;
			mem_y_o = sw_y_i;
			mem_color_o = sw_color_i;
		end
		else if (pm_gnt_o)
		begin
			mem_we_o = pm_we_i;
			mem_x_o = pm_x_i;
			mem_y_o = pm_y_i;
			mem_color_o = pm_color_i;
		end
	end

	a_one_grant: assert property (@(posedge clk) disable iff (reset)
		$onehot0({sw_gnt_o, pm_gnt_o, disp_gnt}));
	a_disp_read_only: assert property (@(posedge clk) disable iff (reset)
		disp_gnt |-> !mem_we_o);

endmodule : board_arbiter

// File: logic/board_ram.sv
`timescale 1ns/1ns
`include "tetris_consts.svh"

module board_ram (
	input  logic       clk,
	input  logic       we_i,
	input  logic [4:0] x_i,
	input  logic [5:0] y_i,
	input  logic [2:0] wcolor_i,
	output logic [2:0] rcolor_o
);

	logic [2:0] cells [`BOARD_H][`BOARD_W];
	logic       in_range;

	assign in_range = (x_i < 5'(`BOARD_W)) && (y_i < 6'(`BOARD_H));

	always_ff @(posedge clk)
	begin
		if (we_i && in_range)
			cells[y_i][x_i] <= wcolor_i;
		if (in_range)
			rcolor_o <= cells[y_i][x_i]; // registered read
		else
			rcolor_o <= `COLOR_EMPTY; // off the board reads as white
	end

endmodule : board_ram

// File: logic/tetris_pkg.sv
package tetris_pkg;

	typedef logic [4:0] board_x_t; // column 0..20
	typedef logic [5:0] board_y_t; // row 0..40, row 0 on top
	typedef logic [2:0] cell_color_t;

	typedef enum logic [1:0] {
		move_down,
		move_left,
		move_right,
		move_none
	} move_op_t;

	typedef enum logic [3:0] {
		ms_idle, ms_check_rd, ms_check_wait, ms_decide, ms_erase, ms_draw, ms_done
	} mover_state_t;

	typedef enum logic [3:0] {
		ss_clear, ss_idle, ss_scan_rd, ss_scan_wait, ss_copy_rd, ss_copy_wait, ss_copy_wr,
		ss_top_clear
	} sweeper_state_t;

endpackage : tetris_pkg

// File: logic/tetris_consts.svh
`ifndef TETRIS_CONSTS_SVH
`define TETRIS_CONSTS_SVH

// playfield geometry
`define BOARD_W 21
`define BOARD_H 41
`define X_MAX 20
`define Y_MAX 40

`define COLOR_EMPTY 3'd7 // white

// keyboard scan codes for the arrows
`define KEY_DOWN 8'h51
`define KEY_LEFT 8'h50
`define KEY_RIGHT 8'h4F

`define PIECE_CELLS 4

`endif
